// File: filelist.f
verilog/paddlePkg.sv
verilog/mouseTracker.sv
verilog/inputSelect.sv
verilog/paddleTimer.sv
verilog/paddlePort.sv
sim/paddlePort_props.sv
sim/tbPaddlePort.sv

// File: Makefile
# Verilator build and run for the paddle port testbench

VERILATOR ?= verilator
TOP       ?= tbPaddlePort
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Testbench passed

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(EXE)
	-./$(EXE) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tbPaddlePort.sv
// paddle port testbench
// walks the DUT through reset, paddle, stick and mouse selection and the
// charge timing, checking each response against a model of the port rules
`timescale 1ns/1ps

module tbPaddlePort;
	import paddlePkg::*;

	logic        clk;
	logic        arstN;
	logic        ce;
	logic        invert;
	posT         paddle;
	logic        paddleBtn;
	logic [15:0] joyA;
	logic        stickBtn;
	logic [24:0] ps2Mouse;
	logic        dump;
	posT         position;
	logic        fire;
	logic        charged;

	string testName;
	int    testErrors;
	int    passCount;
	int    failCount;
	int    accX;
	int    accY;
	logic  strobe;

	paddlePort u_dut (
		.clk       (clk),
		.arstN     (arstN),
		.ce        (ce),
		.invert    (invert),
		.paddle    (paddle),
		.paddleBtn (paddleBtn),
		.joyA      (joyA),
		.stickBtn  (stickBtn),
		.ps2Mouse  (ps2Mouse),
		.dump      (dump),
		.position  (position),
		.fire      (fire),
		.charged   (charged)
	);

	always #50 clk = ~clk;

	task automatic cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		if (testErrors == 0) begin
			$display("PASS %s", testName);
			passCount++;
		end else begin
			$display("FAIL %s with %0d failed checks", testName, testErrors);
			failCount++;
		end
	endtask

	task automatic checkValue(input string what, input int expected, input int actual);
		assert (expected == actual)
		else begin
			$display("FAIL %s: %s expected %0d, actual %0d", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	// signed delta from the packet, clamped, then added with saturation
	function automatic int stepAxis(input int acc, input logic [8:0] raw);
		int delta;
		int sum;
		delta = raw[8] ? int'(raw) - 512 : int'(raw);
		if (delta > 10)
			delta = 10;
		else if (delta < -10)
			delta = -10;
		sum = acc + delta;
		if (sum > 127)
			sum = 127;
		else if (sum < -128)
			sum = -128;
		return sum;
	endfunction

	task automatic sendPacket(input logic [1:0] buttons, input logic [8:0] rawX,
			input logic [8:0] rawY);
		strobe = ~strobe;
		ps2Mouse = {strobe, rawY[7:0], rawX[7:0], 2'b00, rawY[8], rawX[8], 2'b00, buttons};
		accX = stepAxis(accX, rawX);
		accY = stepAxis(accY, rawY);
		cycles(4);
	endtask

	task automatic testPaddle();
		posT expected;
		startTest("paddle");
		for (int i = 0; i < 12; i++) begin
			paddle = 8'($urandom);
			paddleBtn = (i == 0) ? 1'b1 : 1'($urandom);
			invert = (i >= 8);
			cycles(2);
			// top bit of the pot reading is flipped
			expected = paddle ^ 8'h80;
			if (invert)
				expected = ~expected;
			checkValue("position", int'(expected), int'(position));
			checkValue("fire", int'(paddleBtn), int'(fire));
		end
		invert = 1'b0;
		paddleBtn = 1'b0;
		cycles(2);
		endTest();
	endtask

	task automatic testStick();
		startTest("stick");
		stickBtn = 1'b1;
		joyA = 16'($urandom);
		cycles(3);
		checkValue("position", int'(joyA[7:0]), int'(position));
		checkValue("fire", 1, int'(fire));
		stickBtn = 1'b0;
		for (int i = 0; i < 6; i++) begin
			joyA = 16'($urandom);
			cycles(2);
			checkValue("position", int'(joyA[7:0]), int'(position));
			checkValue("fire", 0, int'(fire));
		end
		endTest();
	endtask

	task automatic testMouse();
		startTest("mouse");
		for (int i = 0; i < 12; i++) begin
			sendPacket(2'b00, 9'($urandom), 9'($urandom));
			checkValue("mouse X", accX & 255, int'(position));
			checkValue("fire", 0, int'(fire));
		end
		// right button moves the port to the Y axis
		ps2Mouse[1] = 1'b1;
		cycles(3);
		checkValue("mouse Y", accY & 255, int'(position));
		checkValue("fire", 1, int'(fire));
		for (int i = 0; i < 30; i++) begin
			sendPacket(2'b10, 9'($urandom), 9'd100);
			checkValue("mouse Y", accY & 255, int'(position));
		end
		checkValue("saturated Y", 127, int'(position));
		// left button alone returns the port to the X axis
		ps2Mouse[1:0] = 2'b01;
		cycles(3);
		checkValue("mouse X", accX & 255, int'(position));
		checkValue("fire", 1, int'(fire));
		ps2Mouse[1:0] = 2'b00;
		cycles(2);
		checkValue("fire", 0, int'(fire));
		endTest();
	endtask

	task automatic testCharge(input posT target);
		longint chargeTime;
		int     needed;
		int     ticks;
		chargeTime = longint'(chargeBaseNs) + longint'(target) * 4 * longint'(chargeStepNs);
		needed = int'((chargeTime + longint'(nsPerTick) - 1) / longint'(nsPerTick));
		startTest($sformatf("charge at position %0d", target));
		paddle = target ^ 8'h80;
		paddleBtn = 1'b1;
		cycles(1);
		paddleBtn = 1'b0;
		dump = 1'b1;
		cycles(500);
		checkValue("charged after dump", 0, int'(charged));
		dump = 1'b0;
		ticks = 0;
		while (!charged && ticks < needed + 10) begin
			@(negedge clk);
			ticks++;
		end
		if (!charged) begin
			$display("%s: charged did not rise within %0d ticks", testName, ticks);
			testErrors++;
		end else begin
			assert (ticks > needed && ticks <= needed + 2)
			else begin
				$display("FAIL %s: rise tick expected %0d..%0d, actual %0d",
					testName, needed + 1, needed + 2, ticks);
				testErrors++;
			end
		end
		dump = 1'b1;
		ticks = 0;
		while (charged && ticks < 500) begin
			@(negedge clk);
			ticks++;
		end
		if (charged) begin
			$display("%s: charged stayed high through 500 dump ticks", testName);
			testErrors++;
		end
		endTest();
	endtask

	initial begin
		void'($urandom(9));
		clk = 1'b0;
		arstN = 1'b1;
		ce = 1'b1;
		invert = 1'b0;
		paddle = 8'h80;
		paddleBtn = 1'b0;
		joyA = '0;
		stickBtn = 1'b0;
		ps2Mouse = '0;
		dump = 1'b0;
		strobe = 1'b0;
		accX = 0;
		accY = 0;
		passCount = 0;
		failCount = 0;
		#10 arstN = 1'b0;
		repeat (16) @(negedge clk);
		arstN = 1'b1;

		startTest("reset");
		checkValue("position", 0, int'(position));
		checkValue("fire", 0, int'(fire));
		checkValue("charged", 0, int'(charged));
		endTest();

		testPaddle();
		testStick();
		testMouse();
		testCharge(8'd0);
		testCharge(8'd2);

		$display("tests passed %0d, tests failed %0d, assertion failures %0d",
			passCount, failCount, u_dut.u_props.errorCount);
		if (failCount == 0 && u_dut.u_props.errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: sim/paddlePort_props.sv
// paddle port properties
// concurrent checks on reset state, the paddle data path and the
// dump behavior of the charge timer
`timescale 1ns/1ps

module paddlePortProps (
	input logic               clk,
	input logic               arstN,
	input logic               invert,
	input paddlePkg::posT     paddle,
	input logic               dump,
	input paddlePkg::posT     position,
	input logic               fire,
	input logic               charged,
	input paddlePkg::sourceE  mode
);
	import paddlePkg::*;

	int errorCount = 0;

	// outputs held clear during reset
	resetQuiet: assert property (@(posedge clk) !arstN |-> !fire && !charged)
	else begin
		$error("fire or charged high during reset");
		errorCount++;
	end

	// pot reading reaches position two clocks later with its top bit flipped
	paddlePath: assert property (@(posedge clk) disable iff (!arstN)
		($past(arstN) && $past(arstN, 2) && $past(mode, 2) == srcPaddle && !$past(invert))
		|-> position == {~$past(paddle[7], 2), $past(paddle[6:0], 2)})
	else begin
		$error("paddle position does not follow the paddle input");
		errorCount++;
	end

	// grounded capacitor cannot charge
	noChargeInDump: assert property (@(posedge clk) disable iff (!arstN)
		$rose(charged) |-> !$past(dump))
	else begin
		$error("charged rose while dump was high");
		errorCount++;
	end

endmodule

bind paddlePort paddlePortProps u_props (
	.clk      (clk),
	.arstN    (arstN),
	.invert   (invert),
	.paddle   (paddle),
	.dump     (dump),
	.position (position),
	.fire     (fire),
	.charged  (charged),
	.mode     (u_select.mode)
);

// File: verilog/paddlePort.sv
// Atari paddle input port
// mouse tracker and source selector produce the paddle position,
// which sets the charge time of the paddle timer model
`timescale 1ns/1ps

module paddlePort (
	input  logic           clk,
	input  logic           arstN,
	input  logic           ce,
	input  logic           invert,
	input  paddlePkg::posT paddle,
	input  logic           paddleBtn,
	input  logic [15:0]    joyA,
	input  logic           stickBtn,
	input  logic [24:0]    ps2Mouse,
	input  logic           dump,
	output paddlePkg::posT position,
	output logic           fire,
	output logic           charged
);
	import paddlePkg::*;

	logic mouseEvent;
	posT  mouseX;
	posT  mouseY;

	mouseTracker u_mouse (
		.clk        (clk),
		.arstN      (arstN),
		.ps2Mouse   (ps2Mouse),
		.mouseEvent (mouseEvent),
		.mouseX     (mouseX),
		.mouseY     (mouseY)
	);

	inputSelect u_select (
		.clk        (clk),
		.arstN      (arstN),
		.invert     (invert),
		.paddle     (paddle),
		.paddleBtn  (paddleBtn),
		.joyA       (joyA),
		.stickBtn   (stickBtn),
		.ps2Mouse   (ps2Mouse),
		.mouseEvent (mouseEvent),
		.mouseX     (mouseX),
		.mouseY     (mouseY),
		.position   (position),
		.fire       (fire)
	);

	// selected position doubles as the timer's resistance setting
	paddleTimer u_timer (
		.clk      (clk),
		.arstN    (arstN),
		.ce       (ce),
		.dump     (dump),
		.position (position),
		.charged  (charged)
	);

endmodule

// File: verilog/paddleTimer.sv
// paddle RC charge timer
// models the dump and recharge of the paddle capacitor; charged rises
// once the charge time set by the paddle position has elapsed
`timescale 1ns/1ps

module paddleTimer (
	input  logic           clk,
	input  logic           arstN,
	input  logic           ce,
	input  logic           dump,
	input  paddlePkg::posT position,
	output logic           charged
);
	import paddlePkg::*;

	kohmT kohms;
	nsT   chargeNs;
	nsT   clearCount;
	nsT   highCount;
	logic cleared;
	logic chargeDone;

	// position steps through every fourth of the 1024 resistance indices
	assign kohms = {position, 2'b00};

	// charge time grows linearly with resistance
	assign chargeNs = chargeBaseNs + nsT'(kohms) * chargeStepNs;

	assign cleared    = clearCount >= clearNs;
	assign chargeDone = highCount >= chargeNs;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			clearCount <= '0;
			highCount  <= '0;
			charged    <= 1'b0;
		end else if (ce) begin
			if (dump) begin
				// capacitor grounded, wait for a full discharge
				if (!cleared) begin
					clearCount <= clearCount + nsPerTick;
				end else begin
					highCount <= '0;
					charged   <= 1'b0;
				end
			end else begin
				clearCount <= '0;
				// charging through the pot until the threshold is crossed
				if (!chargeDone)
					highCount <= highCount + nsPerTick;
				else
					charged <= 1'b1;
			end
		end
	end

endmodule

// File: verilog/inputSelect.sv
// input source selector
// picks paddle, stick or mouse as the active pointing source, chooses
// the axis and registers position and fire with optional inversion
`timescale 1ns/1ps

module inputSelect (
	input  logic           clk,
	input  logic           arstN,
	input  logic           invert,
	input  paddlePkg::posT paddle,
	input  logic           paddleBtn,
	input  logic [15:0]    joyA,
	input  logic           stickBtn,
	input  logic [24:0]    ps2Mouse,
	input  logic           mouseEvent,
	input  paddlePkg::posT mouseX,
	input  paddlePkg::posT mouseY,
	output paddlePkg::posT position,
	output logic           fire
);
	import paddlePkg::*;

	sourceE mode;
	logic   ySel;
	logic   stickXHigh;
	posT    nextValue;
	logic   nextFire;
	posT    preValue;
	logic   preFire;

	// stick pushed well to the positive side of X
	assign stickXHigh = !joyA[7] && (joyA[7:0] > 8'd100);

	// later assignments take priority in the mode and axis select
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mode <= srcPaddle;
			ySel <= 1'b0;
		end else begin
			if (mouseEvent)
				mode <= srcMouse;
			if (stickBtn)
				mode <= srcStick;
			if (paddleBtn)
				mode <= srcPaddle;

			if (mode == srcMouse) begin
				if (ps2Mouse[1])
					ySel <= 1'b1;
				if (ps2Mouse[0])
					ySel <= 1'b0;
			end

			if (mode == srcStick && stickXHigh)
				ySel <= 1'b0;
		end
	end

	// value and button of the active source
	always_comb begin
		case (mode)
			srcStick: begin
				nextValue = ySel ? joyA[15:8] : joyA[7:0];
				nextFire  = stickBtn;
			end
			srcMouse: begin
				nextValue = ySel ? mouseY : mouseX;
				nextFire  = |ps2Mouse[1:0];
			end
			default: begin
				// paddle pot reads offset by half scale
				nextValue = {~paddle[7], paddle[6:0]};
				nextFire  = paddleBtn;
			end
		endcase
	end

	// pre-inversion stage followed by the output register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			preValue <= '0;
			preFire  <= 1'b0;
			position <= '0;
			fire     <= 1'b0;
		end else begin
			preValue <= nextValue;
			preFire  <= nextFire;
			position <= invert ? ~preValue : preValue;
			fire     <= preFire;
		end
	end

endmodule

// File: verilog/mouseTracker.sv
// mouse position tracker
// detects a new PS/2 mouse packet from the strobe toggle, clamps the
// X and Y deltas and accumulates them into saturated 8-bit positions
`timescale 1ns/1ps

module mouseTracker (
	input  logic           clk,
	input  logic           arstN,
	input  logic [24:0]    ps2Mouse,
	output logic           mouseEvent,
	output paddlePkg::posT mouseX,
	output paddlePkg::posT mouseY
);
	import paddlePkg::*;

	logic strobePrev;
	logic strobeChange;
	axisT deltaX;
	axisT deltaY;
	axisT accX;
	axisT accY;

	// limit a raw delta to the allowed step size
	function automatic axisT clampDelta(input axisT delta);
		axisT result;
		result = delta;
		if (delta > mouseDeltaMax)
			result = mouseDeltaMax;
		else if (delta < -mouseDeltaMax)
			result = -mouseDeltaMax;
		return result;
	endfunction

	// add a step to an axis and hold the sum inside -128..127
	function automatic axisT saturateAdd(input axisT acc, input axisT delta);
		logic signed [9:0] sum;
		axisT result;
		sum = {acc[8], acc} + {delta[8], delta};
		if (sum > 10'sd127)
			result = 9'sd127;
		else if (sum < -10'sd128)
			result = -9'sd128;
		else
			result = sum[8:0];
		return result;
	endfunction

	// packet sign bits extend the 8-bit deltas to nine bits
	assign deltaX = {ps2Mouse[4], ps2Mouse[15:8]};
	assign deltaY = {ps2Mouse[5], ps2Mouse[23:16]};

	// a new packet is marked only by a change of the strobe level
	assign strobeChange = strobePrev != ps2Mouse[24];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			strobePrev <= 1'b0;
			mouseEvent <= 1'b0;
			accX       <= '0;
			accY       <= '0;
		end else begin
			strobePrev <= ps2Mouse[24];
			mouseEvent <= strobeChange;
			if (strobeChange) begin
				accX <= saturateAdd(accX, clampDelta(deltaX));
				accY <= saturateAdd(accY, clampDelta(deltaY));
			end
		end
	end

	// two's complement low byte is the paddle-style position
	assign mouseX = accX[7:0];
	assign mouseY = accY[7:0];

endmodule

// File: verilog/paddlePkg.sv
// paddle port shared definitions
// position and axis widths, the source select encoding and the
// timing constants of the paddle RC charge model
package paddlePkg;

	// paddle position, also the exported byte of a mouse axis
	typedef logic [7:0] posT;

	// mouse accumulator, wide enough to hold a clamped delta on top of a full axis
	typedef logic signed [8:0] axisT;

	// resistance index into the charge formula
	typedef logic [9:0] kohmT;

	// time in units of ten picoseconds (ns times 100)
	typedef logic [32:0] nsT;

	// active pointing source
	typedef enum logic [1:0] {
		srcPaddle = 2'd0,
		srcStick  = 2'd1,
		srcMouse  = 2'd2
	} sourceE;

	// largest mouse step accepted per packet, either direction
	localparam axisT mouseDeltaMax = 9'sd10;

	// time covered by one ce tick
	localparam nsT nsPerTick = 33'd6984;

	// dump time needed to fully discharge the capacitor
	localparam nsT clearNs = 33'd3352320;

	// charge time at index 0
	localparam nsT chargeBaseNs = 33'd6034284;

	// charge time added per index step
	// the charge curve is linear in the resistance index,
	// so base plus step covers every index
	localparam nsT chargeStepNs = 33'd4532214;

endpackage
